/* sim.f */
common/mc_pkg.sv
endpoint/mc_request_fifo.sv
endpoint/mc_return_fifo.sv
endpoint/mc_endpoint.sv
source/mc_local_mem.sv
source/mc_tile_top.sv
verif/mc_tile_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tile testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module mc_tile_tb -Mdir obj_dir

./obj_dir/Vmc_tile_tb 2>&1 | tee sim.log

# the log decides the result
if grep -q ">>> FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* verif/mc_tile_tb.sv */
// ----------------------------------------
// directed testbench for the tile top level
// loads are only issued to words stored earlier in the run
// core must pop the response FIFO while it is full
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_tile_tb;

  import mc_pkg::*;

  localparam int CLK_HALF   = 20;
  localparam int CLK_PERIOD = 2 * CLK_HALF;
  localparam int BURST_LEN  = 16;
  // reset, store/load, burst, back-pressure, core out, return FIFO
  localparam int TEST_CYCLES = 5 + 12 + (2 * BURST_LEN + 6) + 24 + 3 + 7;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  mc_link_sif_s      link_sif_i;
  mc_link_sif_s      link_sif_o;
  mc_packet_s        out_packet_i;
  logic              out_packet_v_i;
  logic              out_packet_ready_o;
  mc_return_packet_s in_return_packet_o;
  logic              in_return_packet_v_o;
  logic              in_return_packet_yumi_i;
  logic              in_return_fifo_full_o;

  // ----------------------------------------
  // scoreboard state
  logic [31:0]       lfsr_q = 32'he68d;
  mc_data_t          model_mem [mc_addr_t];
  mc_packet_s        req_q [$];
  mc_return_packet_s exp_q [$];
  logic              rev_ready = 1'b1;
  int                cycle_cnt = 0;
  int                acc_cycle = 0;
  int                resp_cycle = 0;
  int                mismatch_cnt = 0;
  int                other_cnt = 0;

  mc_tile_top mc_tile_top_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .link_sif_i(link_sif_i), .link_sif_o(link_sif_o),
    .out_packet_i(out_packet_i), .out_packet_v_i(out_packet_v_i),
    .out_packet_ready_o(out_packet_ready_o),
    .in_return_packet_o(in_return_packet_o), .in_return_packet_v_o(in_return_packet_v_o),
    .in_return_packet_yumi_i(in_return_packet_yumi_i),
    .in_return_fifo_full_o(in_return_fifo_full_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // ----------------------------------------
  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic mc_packet_s rand_request(input mc_opcode_e op, input mc_addr_t addr);
    mc_packet_s p;
    p.op         = op;
    p.addr       = addr;
    p.payload    = rand_bits(MC_DATA_WIDTH);
    p.src_x_cord = mc_x_cord_t'(rand_bits(MC_X_CORD_WIDTH));
    p.src_y_cord = mc_y_cord_t'(rand_bits(MC_Y_CORD_WIDTH));
    p.dst_x_cord = mc_x_cord_t'(rand_bits(MC_X_CORD_WIDTH));
    p.dst_y_cord = mc_y_cord_t'(rand_bits(MC_Y_CORD_WIDTH));
    return p;
  endfunction

  function automatic mc_return_packet_s rand_return();
    mc_return_packet_s r;
    logic [31:0]       b;
    b = rand_bits(1);
    r.return_type = b[0] ? e_return_store_ack : e_return_load_data;
    r.data        = rand_bits(MC_DATA_WIDTH);
    r.dst_x_cord  = mc_x_cord_t'(rand_bits(MC_X_CORD_WIDTH));
    r.dst_y_cord  = mc_y_cord_t'(rand_bits(MC_Y_CORD_WIDTH));
    return r;
  endfunction

  // memory model, answer goes back to the sender
  function automatic mc_return_packet_s predict(input mc_packet_s p);
    mc_return_packet_s r;
    r.dst_x_cord = p.src_x_cord;
    r.dst_y_cord = p.src_y_cord;
    if (p.op == e_op_store) begin
      model_mem[p.addr] = p.payload;
      r.return_type     = e_return_store_ack;
      r.data            = '0;
    end else begin
      r.return_type = e_return_load_data;
      r.data        = model_mem[p.addr];
    end
    return r;
  endfunction

  // ----------------------------------------
  // compare tasks
  task automatic check_return(input mc_return_packet_s got, input mc_return_packet_s exp_pkt,
                              input string what);
    if (got !== exp_pkt) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s got %h expected %h", $time, what, got, exp_pkt);
    end
  endtask

  task automatic check_packet(input mc_packet_s got, input mc_packet_s exp_pkt,
                              input string what);
    if (got !== exp_pkt) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s got %h expected %h", $time, what, got, exp_pkt);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp_bit, input string what);
    if (got !== exp_bit) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s got %b expected %b", $time, what, got, exp_bit);
    end
  endtask

  // ----------------------------------------
  // one cycle of mesh traffic
  // drive on the falling edge, sample once inputs settle
  task automatic step_cycle();
    mc_return_packet_s exp_pkt;
    @(negedge clk_i);
    cycle_cnt++;
    link_sif_i.rev.ready_and_rev = rev_ready;
    link_sif_i.fwd.v             = (req_q.size() > 0);
    if (req_q.size() > 0) link_sif_i.fwd.data = req_q[0];
    #1;
    // transfers complete at the coming rising edge
    if (link_sif_i.fwd.v && link_sif_o.fwd.ready_and_rev) begin
      void'(req_q.pop_front());
      acc_cycle = cycle_cnt;
    end
    if (link_sif_o.rev.v && link_sif_i.rev.ready_and_rev) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("error at %t: memory response arrived with none outstanding", $time);
      end else begin
        exp_pkt = exp_q.pop_front();
        check_return(link_sif_o.rev.data, exp_pkt, "memory response");
        resp_cycle = cycle_cnt;
      end
    end
  endtask

  task automatic queue_request(input mc_packet_s p);
    req_q.push_back(p);
    exp_q.push_back(predict(p));
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while ((req_q.size() > 0 || exp_q.size() > 0) && n < max_cycles) begin
      step_cycle();
      n++;
    end
    if (req_q.size() > 0 || exp_q.size() > 0) begin
      other_cnt++;
      $display("error at %t: %0d requests not accepted and %0d responses missing",
               $time, req_q.size(), exp_q.size());
      req_q.delete();
      exp_q.delete();
    end
  endtask

  // ----------------------------------------
  // tests
  task automatic test_store_load();
    mc_addr_t addr;
    addr = mc_addr_t'(rand_bits(MC_ADDR_WIDTH));
    queue_request(rand_request(e_op_store, addr));
    drain(10);
    check_bit((resp_cycle - acc_cycle) == 2, 1'b1, "store ack 2 cycles after accept");
    queue_request(rand_request(e_op_load, addr));
    drain(10);
    check_bit((resp_cycle - acc_cycle) == 2, 1'b1, "load data 2 cycles after accept");
  endtask

  task automatic test_burst();
    mc_addr_t addrs [BURST_LEN];
    int       i;
    for (i = 0; i < BURST_LEN; i++) begin
      addrs[i] = mc_addr_t'(rand_bits(MC_ADDR_WIDTH));
      queue_request(rand_request(e_op_store, addrs[i]));
    end
    for (i = 0; i < BURST_LEN; i++) queue_request(rand_request(e_op_load, addrs[i]));
    drain(2 * BURST_LEN + 6);
  endtask

  task automatic test_backpressure();
    mc_addr_t addr;
    int       i;
    int       n;
    // store then load pairs, more than FIFO plus memory can hold
    for (i = 0; i < 4; i++) begin
      addr = mc_addr_t'(rand_bits(MC_ADDR_WIDTH));
      queue_request(rand_request(e_op_store, addr));
      queue_request(rand_request(e_op_load, addr));
    end
    rev_ready = 1'b0;
    n = 0;
    while (link_sif_o.fwd.ready_and_rev && n < 10) begin
      step_cycle();
      n++;
    end
    check_bit(link_sif_o.fwd.ready_and_rev, 1'b0, "forward ready drops when stalled");
    rev_ready = 1'b1;
    drain(20);
    step_cycle();
    check_bit(link_sif_o.fwd.ready_and_rev, 1'b1, "forward ready high after drain");
  endtask

  task automatic test_core_out();
    mc_packet_s p;
    p = rand_request(e_op_store, mc_addr_t'(rand_bits(MC_ADDR_WIDTH)));
    @(negedge clk_i);
    out_packet_i                 = p;
    out_packet_v_i               = 1'b1;
    link_sif_i.fwd.ready_and_rev = 1'b0;
    #1;
    check_bit(link_sif_o.fwd.v, 1'b1, "outgoing valid on the link");
    check_packet(link_sif_o.fwd.data, p, "outgoing request");
    check_bit(out_packet_ready_o, 1'b0, "core ready follows mesh ready low");
    link_sif_i.fwd.ready_and_rev = 1'b1;
    #1;
    check_bit(out_packet_ready_o, 1'b1, "core ready follows mesh ready high");
    @(negedge clk_i);
    out_packet_v_i = 1'b0;
    #1;
    check_bit(link_sif_o.fwd.v, 1'b0, "outgoing valid drops");
  endtask

  task automatic test_return_fifo();
    mc_return_packet_s r [3];
    int                i;
    for (i = 0; i < 3; i++) r[i] = rand_return();
    @(negedge clk_i);
    link_sif_i.rev.v        = 1'b1;
    link_sif_i.rev.data     = r[0];
    in_return_packet_yumi_i = 1'b0;
    @(negedge clk_i);
    link_sif_i.rev.data = r[1];
    #1;
    check_bit(in_return_packet_v_o, 1'b1, "response visible next cycle");
    // third arrival meets a full FIFO, pop in the same cycle
    @(negedge clk_i);
    link_sif_i.rev.data     = r[2];
    in_return_packet_yumi_i = 1'b1;
    #1;
    check_bit(in_return_fifo_full_o, 1'b1, "full after two responses");
    check_bit(link_sif_o.rev.ready_and_rev, 1'b1, "reverse ready tied high");
    check_return(in_return_packet_o, r[0], "first queued response");
    for (i = 1; i < 3; i++) begin
      @(negedge clk_i);
      link_sif_i.rev.v = 1'b0;
      #1;
      check_bit(in_return_packet_v_o, 1'b1, "queued response valid");
      check_return(in_return_packet_o, r[i], "queued response order");
    end
    @(negedge clk_i);
    in_return_packet_yumi_i = 1'b0;
    #1;
    check_bit(in_return_packet_v_o, 1'b0, "return FIFO empty");
    check_bit(in_return_fifo_full_o, 1'b0, "return FIFO not full");
    check_bit(link_sif_o.rev.ready_and_rev, 1'b1, "reverse ready still high");
  endtask

  // ----------------------------------------
  // watchdog, summed test lengths plus margin
  initial begin
    #((TEST_CYCLES + 40) * CLK_PERIOD);
    $display("timeout at %t: tests did not finish", $time);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n_i                      = 1'b0;
    link_sif_i                   = '0;
    link_sif_i.fwd.ready_and_rev = 1'b1;
    link_sif_i.rev.ready_and_rev = 1'b1;
    out_packet_i                 = '0;
    out_packet_v_i               = 1'b0;
    in_return_packet_yumi_i      = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_bit(link_sif_o.fwd.ready_and_rev, 1'b1, "forward ready after reset");
    check_bit(link_sif_o.rev.v, 1'b0, "response valid after reset");
    check_bit(in_return_packet_v_o, 1'b0, "return FIFO valid after reset");
    test_store_load();
    test_burst();
    test_backpressure();
    test_core_out();
    test_return_fifo();
    $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/mc_tile_top.sv */
// ----------------------------------------
// tile top, endpoint plus local memory
// core ports are left open to the outside
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_tile_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // mesh
  input  mc_pkg::mc_link_sif_s      link_sif_i,
  output mc_pkg::mc_link_sif_s      link_sif_o,
  // core outgoing requests
  input  mc_pkg::mc_packet_s        out_packet_i,
  input  logic                      out_packet_v_i,
  output logic                      out_packet_ready_o,
  // core incoming responses
  output mc_pkg::mc_return_packet_s in_return_packet_o,
  output logic                      in_return_packet_v_o,
  input  logic                      in_return_packet_yumi_i,
  output logic                      in_return_fifo_full_o
);

  import mc_pkg::*;

  // endpoint to memory
  mc_packet_s        req_packet;
  logic              req_v;
  logic              req_yumi;
  mc_return_packet_s resp_packet;
  logic              resp_v;
  logic              resp_ready;

  mc_endpoint endpoint_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .link_sif_i(link_sif_i), .link_sif_o(link_sif_o),
    .req_packet_o(req_packet), .req_v_o(req_v), .req_yumi_i(req_yumi),
    .resp_packet_i(resp_packet), .resp_v_i(resp_v), .resp_ready_o(resp_ready),
    .out_packet_i(out_packet_i), .out_packet_v_i(out_packet_v_i),
    .out_packet_ready_o(out_packet_ready_o),
    .in_return_packet_o(in_return_packet_o), .in_return_packet_v_o(in_return_packet_v_o),
    .in_return_packet_yumi_i(in_return_packet_yumi_i),
    .in_return_fifo_full_o(in_return_fifo_full_o)
  );

  mc_local_mem local_mem_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_packet_i(req_packet), .req_v_i(req_v), .req_yumi_o(req_yumi),
    .resp_packet_o(resp_packet), .resp_v_o(resp_v), .resp_ready_i(resp_ready)
  );

endmodule

`default_nettype wire

/* source/mc_local_mem.sv */
// ----------------------------------------
// local word memory serving remote loads and stores
// no reset on the array, loads see data only after a store
// one registered response, held until taken
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_local_mem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // requests from the endpoint FIFO
  input  mc_pkg::mc_packet_s        req_packet_i,
  input  logic                      req_v_i,
  output logic                      req_yumi_o,
  // response toward the mesh
  output mc_pkg::mc_return_packet_s resp_packet_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i
);

  import mc_pkg::*;

  mc_mem_state_e     state_r;
  mc_data_t          mem_r [MC_MEM_WORDS];
  mc_return_packet_s resp_r;
  logic              pop;

  // ----------------------------------------
  // pop when the response slot is free or drains this cycle
  assign pop           = req_v_i & ((state_r == e_idle) | resp_ready_i);
  assign req_yumi_o    = pop;
  assign resp_v_o      = (state_r == e_respond);
  assign resp_packet_o = resp_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_idle;
    end else begin
      unique case (state_r)
        e_idle: begin
          if (pop) state_r <= e_respond;
        end
        e_respond: begin
          // back to back requests stay in respond
          if (resp_ready_i && !pop) state_r <= e_idle;
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  // ----------------------------------------
  // array access and response build
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (req_packet_i.op == e_op_store) begin
        mem_r[req_packet_i.addr] <= req_packet_i.payload;
        resp_r.return_type       <= e_return_store_ack;
        resp_r.data              <= '0;
      end else begin
        resp_r.return_type <= e_return_load_data;
        resp_r.data        <= mem_r[req_packet_i.addr];
      end
      // answer goes back to the sender
      resp_r.dst_x_cord <= req_packet_i.src_x_cord;
      resp_r.dst_y_cord <= req_packet_i.src_y_cord;
    end
  end

  // stalled response must not move
  a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_packet_o)));

endmodule

`default_nettype wire

/* endpoint/mc_endpoint.sv */
// ----------------------------------------
// tile endpoint between the mesh link and the core / memory ports
// core must pop the response FIFO whenever it is full
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_endpoint (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // mesh link
  input  mc_pkg::mc_link_sif_s      link_sif_i,
  output mc_pkg::mc_link_sif_s      link_sif_o,
  // incoming requests to local memory
  output mc_pkg::mc_packet_s        req_packet_o,
  output logic                      req_v_o,
  input  logic                      req_yumi_i,
  // responses from local memory
  input  mc_pkg::mc_return_packet_s resp_packet_i,
  input  logic                      resp_v_i,
  output logic                      resp_ready_o,
  // outgoing core requests
  input  mc_pkg::mc_packet_s        out_packet_i,
  input  logic                      out_packet_v_i,
  output logic                      out_packet_ready_o,
  // incoming responses for the core
  output mc_pkg::mc_return_packet_s in_return_packet_o,
  output logic                      in_return_packet_v_o,
  input  logic                      in_return_packet_yumi_i,
  output logic                      in_return_fifo_full_o
);

  logic req_fifo_ready;
  logic ret_fifo_ready;

  // ----------------------------------------
  // incoming requests are buffered since memory may stall
  mc_request_fifo req_fifo_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .v_i(link_sif_i.fwd.v), .data_i(link_sif_i.fwd.data), .ready_o(req_fifo_ready),
    .v_o(req_v_o), .data_o(req_packet_o), .yumi_i(req_yumi_i)
  );
  assign link_sif_o.fwd.ready_and_rev = req_fifo_ready;

  // memory responses straight out
  assign link_sif_o.rev.v    = resp_v_i;
  assign link_sif_o.rev.data = resp_packet_i;
  assign resp_ready_o        = link_sif_i.rev.ready_and_rev;

  // core requests straight out
  assign link_sif_o.fwd.v    = out_packet_v_i;
  assign link_sif_o.fwd.data = out_packet_i;
  assign out_packet_ready_o  = link_sif_i.fwd.ready_and_rev;

  // ----------------------------------------
  // incoming responses are never refused on the mesh
  mc_return_fifo ret_fifo_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .v_i(link_sif_i.rev.v), .data_i(link_sif_i.rev.data), .ready_o(ret_fifo_ready),
    .v_o(in_return_packet_v_o), .data_o(in_return_packet_o), .yumi_i(in_return_packet_yumi_i)
  );
  assign in_return_fifo_full_o        = ~ret_fifo_ready;
  assign link_sif_o.rev.ready_and_rev = 1'b1;

  // core side has to drain a full FIFO
  a_full_needs_yumi : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_return_fifo_full_o |-> in_return_packet_yumi_i);

  // a response arriving on a full FIFO needs a pop in that same cycle
  a_enq_deq_on_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (link_sif_i.rev.v && in_return_fifo_full_o) |-> in_return_packet_yumi_i);

endmodule

`default_nettype wire

/* endpoint/mc_return_fifo.sv */
// ----------------------------------------
// two-slot response FIFO, head slot is the output
// takes a new entry while full if the head leaves that cycle
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_return_fifo (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      v_i,
  input  mc_pkg::mc_return_packet_s data_i,
  output logic                      ready_o,
  output logic                      v_o,
  output mc_pkg::mc_return_packet_s data_o,
  input  logic                      yumi_i
);

  import mc_pkg::*;

  mc_return_packet_s head_r;
  mc_return_packet_s tail_r;
  logic              head_v_r;
  logic              tail_v_r;
  logic              enq;

  // tail only holds data when head does, so tail valid means full
  assign ready_o = ~tail_v_r;
  assign v_o     = head_v_r;
  assign data_o  = head_r;
  assign enq     = v_i & (~tail_v_r | yumi_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_v_r <= 1'b0;
      tail_v_r <= 1'b0;
    end else begin
      head_v_r <= enq | (head_v_r & ~yumi_i) | tail_v_r;
      tail_v_r <= (tail_v_r & ~yumi_i) | (enq & head_v_r & ~yumi_i) | (enq & tail_v_r & yumi_i);
    end
  end

  // data slots
  always_ff @(posedge clk_i) begin
    // tail moves up on a pop, else new data lands in an empty or leaving head
    if (yumi_i && tail_v_r) head_r <= tail_r;
    else if (enq && (!head_v_r || yumi_i)) head_r <= data_i;
    if (enq && ((head_v_r && !yumi_i) || (tail_v_r && yumi_i))) tail_r <= data_i;
  end

  a_yumi_needs_v : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

/* endpoint/mc_request_fifo.sv */
// ----------------------------------------
// ring FIFO for incoming requests
// els_p must be a power of two and at least 2
// ready/valid on the input and valid/yumi on the output, no bypass
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mc_request_fifo #(
  parameter int els_p = mc_pkg::MC_REQ_FIFO_ELS
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               v_i,
  input  mc_pkg::mc_packet_s data_i,
  output logic               ready_o,
  output logic               v_o,
  output mc_pkg::mc_packet_s data_o,
  input  logic               yumi_i
);

  import mc_pkg::*;

  // payload slots
  mc_packet_s mem_r [els_p];

  // pointers carry an extra wrap bit
  logic [$clog2(els_p):0] wr_ptr_r;
  logic [$clog2(els_p):0] rd_ptr_r;
  logic [$clog2(els_p):0] count;
  logic                   empty;
  logic                   full;
  logic                   wr_en;

  assign empty = (wr_ptr_r == rd_ptr_r);
  // same slot but opposite wrap bit
  assign full = (wr_ptr_r[$clog2(els_p)] != rd_ptr_r[$clog2(els_p)])
              && (wr_ptr_r[$clog2(els_p)-1:0] == rd_ptr_r[$clog2(els_p)-1:0]);

  // entries held, wraps with the pointers
  assign count = wr_ptr_r - rd_ptr_r;

  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r[$clog2(els_p)-1:0]];
  assign wr_en   = v_i & ready_o;

  // ----------------------------------------
  // pointer update
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (wr_en) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (yumi_i) rd_ptr_r <= rd_ptr_r + 1'b1;
    end
  end

  // payload write
  always_ff @(posedge clk_i) begin
    if (wr_en) mem_r[wr_ptr_r[$clog2(els_p)-1:0]] <= data_i;
  end

  // ----------------------------------------
  // consumer pops only what is offered
  a_yumi_needs_v : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

  // a write never lands while all entries are held
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en |-> (count < els_p));

endmodule

`default_nettype wire

/* common/mc_pkg.sv */
// ----------------------------------------
// shared widths and packet layouts for the tile endpoint
// request packet is 57 bits, response packet is 40 bits
// ----------------------------------------
`default_nettype none

package mc_pkg;

  // ----------------------------------------
  // widths and sizes
  localparam int MC_X_CORD_WIDTH = 4;
  localparam int MC_Y_CORD_WIDTH = 3;
  localparam int MC_ADDR_WIDTH   = 10;
  localparam int MC_DATA_WIDTH   = 32;
  localparam int MC_REQ_FIFO_ELS = 4;
  localparam int MC_MEM_WORDS    = 1024;

  typedef logic [MC_X_CORD_WIDTH-1:0] mc_x_cord_t;
  typedef logic [MC_Y_CORD_WIDTH-1:0] mc_y_cord_t;
  typedef logic [MC_ADDR_WIDTH-1:0]   mc_addr_t;
  typedef logic [MC_DATA_WIDTH-1:0]   mc_data_t;

  typedef enum logic {e_op_load = 1'b0, e_op_store = 1'b1} mc_opcode_e;
  typedef enum logic {e_return_load_data = 1'b0, e_return_store_ack = 1'b1} mc_return_type_e;
  typedef enum logic {e_idle = 1'b0, e_respond = 1'b1} mc_mem_state_e;

  // ----------------------------------------
  // packets
  typedef struct packed {
    mc_opcode_e op;
    mc_addr_t   addr;
    mc_data_t   payload;
    mc_x_cord_t src_x_cord;
    mc_y_cord_t src_y_cord;
    mc_x_cord_t dst_x_cord;
    mc_y_cord_t dst_y_cord;
  } mc_packet_s;

  // dst is the requester, taken from the request's src
  typedef struct packed {
    mc_return_type_e return_type;
    mc_data_t        data;
    mc_x_cord_t      dst_x_cord;
    mc_y_cord_t      dst_y_cord;
  } mc_return_packet_s;

  // ----------------------------------------
  // links
  // ready_and_rev is the ready for traffic flowing the other way
  typedef struct packed {
    logic       v;
    mc_packet_s data;
    logic       ready_and_rev;
  } mc_fwd_link_s;

  typedef struct packed {
    logic              v;
    mc_return_packet_s data;
    logic              ready_and_rev;
  } mc_rev_link_s;

  typedef struct packed {
    mc_fwd_link_s fwd;
    mc_rev_link_s rev;
  } mc_link_sif_s;

endpackage

`default_nettype wire
